// File: src/xc_settings.svh
// Sizes of the correlator core; XC_COUNT_W must stay 16 (two bytes per word), XC_NUM_LAGS >= 2.
`ifndef XC_SETTINGS_SVH
`define XC_SETTINGS_SVH

// detector lines and lag range.
`define XC_NUM_LINES 4
`define XC_NUM_LAGS 2

// ordered pairs i<=j, must equal n*(n+1)/2.
`define XC_NUM_PAIRS 10

// accepted samples per integration, at least 2.
`define XC_INTEG_SAMPLES 16

// width of one coincidence counter.
`define XC_COUNT_W 16

// credit link depths.
`define XC_WORD_DEPTH 4
`define XC_BYTE_DEPTH 4

// credits held by the external receiver out of reset.
`define XC_OUT_CREDITS 4

// first byte of each frame.
`define XC_FRAME_HEADER 8'hA5

`endif

// File: src/xc_pkg.sv
// Link types of the correlator pipeline; sizes come from xc_settings.svh and need NUM_LAGS >= 2.
`include "xc_settings.svh"

package xc_pkg;

    // one registered sample of all lines.
    typedef struct packed {
        logic [`XC_NUM_LINES-1:0] lines;   // line levels, gated by enable.
        logic                     valid;   // one cycle per accepted sample.
        logic                     last;    // closes the integration.
    } line_sample_t;

    // current vector plus its delayed copies.
    typedef struct packed {
        logic [`XC_NUM_LINES-1:0]                     cur;
        logic [`XC_NUM_LAGS-2:0][`XC_NUM_LINES-1:0]   past;    // past[k-1] is k samples back.
        logic                                         valid;
        logic                                         last;
    } lag_window_t;

    // one counter value on its way to the framer.
    typedef struct packed {
        logic [`XC_COUNT_W-1:0] count;
        logic                   frame_last;   // final word of a result set.
    } result_word_t;

    // one byte of the output stream.
    typedef struct packed {
        logic [7:0] data;
    } link_byte_t;

endpackage

// File: src/xc_line_sampler.sv
// Samples the lines on smp_en while enable is high; smp_en must be synchronous to sysclk.
`timescale 1ns/100ps
`include "xc_settings.svh"

module xc_line_sampler (
    input  logic                     sysclk,
    input  logic                     arst_n,
    input  logic [`XC_NUM_LINES-1:0] line_in,
    input  logic                     smp_en,
    input  logic                     enable,
    output xc_pkg::line_sample_t     sample
);

    localparam int CNT_W = $clog2(`XC_INTEG_SAMPLES);

    logic                     take;
    logic [CNT_W-1:0]         smp_cnt_q;
    logic [`XC_NUM_LINES-1:0] lines_q;
    logic                     valid_q;
    logic                     last_q;

    assign take = smp_en & enable;   // disabled strobes are dropped.

    // count accepted samples, flag the closing one.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            smp_cnt_q <= '0;
            valid_q   <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            valid_q <= take;
            if (take) begin
                if (smp_cnt_q == CNT_W'(`XC_INTEG_SAMPLES - 1)) begin
                    smp_cnt_q <= '0;   // next integration.
                    last_q    <= 1'b1;
                end else begin
                    smp_cnt_q <= smp_cnt_q + 1'b1;
                    last_q    <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (take)
            lines_q <= line_in;   // line levels.
    end

    assign sample.lines = lines_q;
    assign sample.valid = valid_q;
    assign sample.last  = last_q & valid_q;   // last only with its sample.

endmodule

// File: src/xc_lag_window.sv
// Lag history of the accepted samples; starts from zero after reset and runs across integrations.
`timescale 1ns/100ps
`include "xc_settings.svh"

module xc_lag_window (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  xc_pkg::line_sample_t sample,
    output xc_pkg::lag_window_t  window
);

    localparam int N = `XC_NUM_LINES;
    localparam int HIST = `XC_NUM_LAGS - 1;

    logic [N-1:0]            cur_q;
    logic [HIST-1:0][N-1:0]  hist_q;    // hist_q[k-1] is k samples behind cur_q.
    logic                    valid_q;
    logic                    last_q;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_q   <= '0;
            hist_q  <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= sample.valid;
            last_q  <= sample.last;
            if (sample.valid) begin
                cur_q     <= sample.lines;
                hist_q[0] <= cur_q;   // previous sample moves back one lag.
                for (int k = 1; k < HIST; k++) begin
                    hist_q[k] <= hist_q[k-1];
                end
            end
        end
    end

    assign window.cur   = cur_q;
    assign window.past  = hist_q;
    assign window.valid = valid_q;
    assign window.last  = last_q;

endmodule

// File: src/xc_correlator.sv
// Pair/lag coincidence counters with one shadow bank; a result ending during readout is lost.
`timescale 1ns/100ps
`include "xc_settings.svh"

module xc_correlator (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  xc_pkg::lag_window_t  window,
    output logic                 word_valid,
    output xc_pkg::result_word_t word,
    input  logic                 word_credit,
    output logic                 overrun
);

    localparam int N     = `XC_NUM_LINES;
    localparam int LAGS  = `XC_NUM_LAGS;
    localparam int WORDS = `XC_NUM_PAIRS * `XC_NUM_LAGS;
    localparam int CNT_W = `XC_COUNT_W;
    localparam int IDX_W = $clog2(WORDS);
    localparam int CRD_W = $clog2(`XC_WORD_DEPTH + 1);

    logic [LAGS-1:0][N-1:0] lag_vec;    // lag_vec[k] is k samples back.
    logic [WORDS-1:0]       hit;
    logic [CNT_W-1:0]       cnt_q [WORDS];
    logic [CNT_W-1:0]       shadow_q [WORDS];
    logic                   closing;
    logic                   load;
    logic                   send;
    logic                   frame_end;
    logic                   busy_q;
    logic [IDX_W-1:0]       rd_idx_q;
    logic [CRD_W-1:0]       credit_q;
    logic                   word_valid_q;
    logic                   overrun_q;
    xc_pkg::result_word_t   word_q;

    assign lag_vec[0] = window.cur;
    for (genvar k = 1; k < LAGS; k++) begin : g_past
        assign lag_vec[k] = window.past[k-1];
    end

    // word index is pair-major, lag-minor.
    for (genvar i = 0; i < N; i++) begin : g_li
        for (genvar j = i; j < N; j++) begin : g_lj
            localparam int P = i * N - (i * (i - 1)) / 2 + (j - i);
            for (genvar k = 0; k < LAGS; k++) begin : g_lag
                assign hit[P*LAGS + k] = window.cur[i] & lag_vec[k][j];
            end
        end
    end

    assign closing   = window.valid & window.last;
    assign load      = closing & ~busy_q;           // shadow free, take the result.
    assign send      = busy_q && (credit_q != '0);
    assign frame_end = (rd_idx_q == IDX_W'(WORDS - 1));

    // live counters, restart after the closing sample.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < WORDS; n++) begin
                cnt_q[n] <= '0;
            end
        end else if (window.valid) begin
            for (int n = 0; n < WORDS; n++) begin
                if (window.last)
                    cnt_q[n] <= '0;
                else
                    cnt_q[n] <= cnt_q[n] + {{(CNT_W-1){1'b0}}, hit[n]};
            end
        end
    end

    // shadow bank includes the closing sample.
    always_ff @(posedge sysclk) begin
        if (load) begin
            for (int n = 0; n < WORDS; n++) begin
                shadow_q[n] <= cnt_q[n] + {{(CNT_W-1){1'b0}}, hit[n]};
            end
        end
    end

    // readout sequencing and credits.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q       <= 1'b0;
            rd_idx_q     <= '0;
            credit_q     <= CRD_W'(`XC_WORD_DEPTH);
            word_valid_q <= 1'b0;
            overrun_q    <= 1'b0;
        end else begin
            word_valid_q <= send;
            if (send) begin
                if (frame_end) begin
                    busy_q   <= 1'b0;
                    rd_idx_q <= '0;
                end else begin
                    rd_idx_q <= rd_idx_q + 1'b1;
                end
            end
            if (load)
                busy_q <= 1'b1;
            if (closing && busy_q)
                overrun_q <= 1'b1;   // sticky.
            case ({send, word_credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (send) begin
            word_q.count      <= shadow_q[rd_idx_q];
            word_q.frame_last <= frame_end;
        end
    end

    assign word_valid = word_valid_q;
    assign word       = word_q;
    assign overrun    = overrun_q;

endmodule

// File: src/xc_credit_fifo.sv
// Credit-fed FIFO; the sender must hold depth credits, so a push always finds room.
`timescale 1ns/100ps

module xc_credit_fifo #(
    parameter type payload_t    = logic,
    parameter int  depth        = 4,
    parameter int  init_credits = depth
) (
    input  logic     sysclk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_credit,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_credit
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);
    localparam int CRD_W = $clog2(init_credits + 1);

    payload_t         mem [depth];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CRD_W-1:0] credit_q;    // downstream credits.
    logic             pop;
    logic             in_credit_q;

    assign pop       = (count_q != '0) && (credit_q != '0);
    assign out_valid = pop;                 // head shown the cycle after its write.
    assign out_data  = mem[rd_ptr_q];
    assign in_credit = in_credit_q;

    always_ff @(posedge sysclk) begin
        if (in_valid)
            mem[wr_ptr_q] <= in_data;
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            credit_q    <= CRD_W'(init_credits);
            in_credit_q <= 1'b0;
        end else begin
            in_credit_q <= pop;   // freed slot goes back upstream.
            if (in_valid)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            case ({in_valid, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
            case ({pop, out_credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: src/xc_framer.sv
// Frames result words as header, two bytes per word, XOR checksum; holds one word at a time.
`timescale 1ns/100ps
`include "xc_settings.svh"

module xc_framer (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic                 word_valid,
    input  xc_pkg::result_word_t word,
    output logic                 word_credit,
    output logic                 byte_valid,
    output xc_pkg::link_byte_t   byte_out,
    input  logic                 byte_credit
);

    localparam int CRD_W = $clog2(`XC_BYTE_DEPTH + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_HI,
        S_LO,
        S_CSUM
    } state_t;

    state_t               state_q;
    logic                 sof_q;         // next word opens a frame.
    logic                 have_word_q;
    logic [7:0]           csum_q;
    logic [CRD_W-1:0]     credit_q;
    logic                 byte_valid_q;
    logic                 word_credit_q;
    logic                 emit;
    logic [7:0]           tx_data;
    xc_pkg::result_word_t hold_q;
    xc_pkg::link_byte_t   byte_q;

    assign emit = (state_q != S_IDLE) && (credit_q != '0);

    always_comb begin
        case (state_q)
            S_HDR:   tx_data = `XC_FRAME_HEADER;
            S_HI:    tx_data = hold_q.count[15:8];   // msb first.
            S_LO:    tx_data = hold_q.count[7:0];
            default: tx_data = csum_q;
        endcase
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= S_IDLE;
            sof_q         <= 1'b1;
            have_word_q   <= 1'b0;
            csum_q        <= '0;
            credit_q      <= CRD_W'(`XC_BYTE_DEPTH);
            byte_valid_q  <= 1'b0;
            word_credit_q <= 1'b0;
        end else begin
            byte_valid_q  <= emit;
            word_credit_q <= 1'b0;
            if (emit) begin
                case (state_q)
                    S_HDR: begin
                        csum_q  <= '0;   // header not in checksum.
                        state_q <= S_HI;
                    end
                    S_HI: begin
                        csum_q  <= csum_q ^ tx_data;
                        state_q <= S_LO;
                    end
                    S_LO: begin
                        csum_q        <= csum_q ^ tx_data;
                        have_word_q   <= 1'b0;
                        word_credit_q <= 1'b1;   // word slot free again.
                        state_q       <= hold_q.frame_last ? S_CSUM : S_IDLE;
                    end
                    default: begin
                        sof_q   <= 1'b1;   // checksum closes the frame.
                        state_q <= S_IDLE;
                    end
                endcase
            end else if (state_q == S_IDLE && have_word_q) begin
                state_q <= sof_q ? S_HDR : S_HI;
                sof_q   <= 1'b0;
            end
            if (word_valid)
                have_word_q <= 1'b1;
            case ({emit, byte_credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (word_valid)
            hold_q <= word;
        if (emit)
            byte_q.data <= tx_data;
    end

    assign word_credit = word_credit_q;
    assign byte_valid  = byte_valid_q;
    assign byte_out    = byte_q;

endmodule

// File: src/xc_core.sv
// Correlator core top; smp_en and enable are synchronous to sysclk, out_credit returns one byte each.
`timescale 1ns/100ps
`include "xc_settings.svh"

module xc_core (
    input  logic                     sysclk,
    input  logic                     arst_n,
    input  logic [`XC_NUM_LINES-1:0] line_in,
    input  logic                     smp_en,
    input  logic                     enable,
    output logic                     out_valid,
    output xc_pkg::link_byte_t       out_byte,
    input  logic                     out_credit,
    output logic                     overrun
);

    xc_pkg::line_sample_t sample;
    xc_pkg::lag_window_t  window;
    logic                 cw_valid;     // correlator to word FIFO.
    xc_pkg::result_word_t cw_word;
    logic                 cw_credit;
    logic                 wf_valid;     // word FIFO to framer.
    xc_pkg::result_word_t wf_word;
    logic                 wf_credit;
    logic                 fb_valid;     // framer to byte FIFO.
    xc_pkg::link_byte_t   fb_byte;
    logic                 fb_credit;

    xc_line_sampler i_sampler (
        .sysclk (sysclk),
        .arst_n (arst_n),
        .line_in(line_in),
        .smp_en (smp_en),
        .enable (enable),
        .sample (sample)
    );

    xc_lag_window i_lag_window (
        .sysclk(sysclk),
        .arst_n(arst_n),
        .sample(sample),
        .window(window)
    );

    xc_correlator i_correlator (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .window     (window),
        .word_valid (cw_valid),
        .word       (cw_word),
        .word_credit(cw_credit),
        .overrun    (overrun)
    );

    // framer holds a single word, so one credit downstream.
    xc_credit_fifo #(
        .payload_t   (xc_pkg::result_word_t),
        .depth       (`XC_WORD_DEPTH),
        .init_credits(1)
    ) i_word_fifo (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .in_valid  (cw_valid),
        .in_data   (cw_word),
        .in_credit (cw_credit),
        .out_valid (wf_valid),
        .out_data  (wf_word),
        .out_credit(wf_credit)
    );

    xc_framer i_framer (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .word_valid (wf_valid),
        .word       (wf_word),
        .word_credit(wf_credit),
        .byte_valid (fb_valid),
        .byte_out   (fb_byte),
        .byte_credit(fb_credit)
    );

    xc_credit_fifo #(
        .payload_t   (xc_pkg::link_byte_t),
        .depth       (`XC_BYTE_DEPTH),
        .init_credits(`XC_OUT_CREDITS)
    ) i_byte_fifo (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .in_valid  (fb_valid),
        .in_data   (fb_byte),
        .in_credit (fb_credit),
        .out_valid (out_valid),
        .out_data  (out_byte),
        .out_credit(out_credit)
    );

endmodule

// File: bench/xc_clock_gen.sv
// Bench clock and reset; 4 ns period, arst_n released on a rising edge after 16 cycles.
`timescale 1ns/100ps

module xc_clock_gen #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 16
) (
    output logic sysclk,
    output logic arst_n
);

    initial begin
        sysclk = 1'b0;
        forever #(half_period) sysclk = ~sysclk;
    end

    initial begin
        arst_n = 1'b0;   // reset from time zero.
        repeat (reset_cycles) @(posedge sysclk);
        arst_n <= 1'b1;
    end

endmodule

// File: bench/xc_core_assertions.sv
// Credit and fill checks bound into every xc_credit_fifo; widths follow the bound instance.
`timescale 1ns/100ps

module xc_core_assertions #(
    parameter int depth        = 4,
    parameter int init_credits = depth,
    parameter int cnt_w        = 3,
    parameter int crd_w        = 3
) (
    input logic             sysclk,
    input logic             arst_n,
    input logic             in_valid,
    input logic             out_valid,
    input logic             out_credit,
    input logic [cnt_w-1:0] count_q,
    input logic [crd_w-1:0] credit_q
);

    int avail_q;   // downstream credits as seen on the pins.

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            avail_q <= init_credits;
        else
            avail_q <= avail_q - int'(out_valid) + int'(out_credit);
    end

    // a pop always spends a credit that the receiver handed out.
    a_valid_needs_credit: assert property (@(posedge sysclk) disable iff (!arst_n)
        out_valid |-> (avail_q > 0))
        else $error("fifo out_valid high with zero downstream credits");

    a_fill_in_range: assert property (@(posedge sysclk) disable iff (!arst_n)
        count_q <= depth)
        else $error("fifo item count above its depth");

    // push into a full buffer only when the head leaves the same cycle.
    a_no_overflow: assert property (@(posedge sysclk) disable iff (!arst_n)
        in_valid |-> ((count_q < depth) || out_valid))
        else $error("fifo written while full");

    a_credit_bounded: assert property (@(posedge sysclk) disable iff (!arst_n)
        credit_q <= init_credits)
        else $error("fifo credit counter above its reset value");

endmodule

bind xc_credit_fifo xc_core_assertions #(
    .depth       (depth),
    .init_credits(init_credits),
    .cnt_w       (CNT_W),
    .crd_w       (CRD_W)
) i_assertions (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_credit(out_credit),
    .count_q   (count_q),
    .credit_q  (credit_q)
);

// File: bench/xc_tb.sv
// Directed bench for xc_core; one strobe every 2 cycles, frames drained between integrations.
`timescale 1ns/100ps
`include "xc_settings.svh"

module xc_tb;

    localparam int num_lines      = `XC_NUM_LINES;
    localparam int num_lags       = `XC_NUM_LAGS;
    localparam int integ          = `XC_INTEG_SAMPLES;
    localparam int words          = `XC_NUM_PAIRS * `XC_NUM_LAGS;
    localparam int frame_bytes    = 2 * words + 2;   // header, counts, checksum.
    localparam int smp_div        = 2;
    localparam int num_tests      = 5;
    localparam int frame_cycles   = integ * smp_div + frame_bytes * 4;
    localparam int timeout_cycles = num_tests * 4 * frame_cycles;
    localparam int single_line    = 2;
    localparam int mode_random    = 0;
    localparam int mode_ones      = 1;
    localparam int mode_zeros     = 2;
    localparam int mode_single    = 3;
    localparam int mode_alt       = 4;

    logic                 sysclk;
    logic                 arst_n;
    logic [num_lines-1:0] line_in;
    logic                 smp_en;
    logic                 enable;
    logic                 out_valid;
    xc_pkg::link_byte_t   out_byte;
    logic                 out_credit;
    logic                 overrun;

    logic [31:0]          rng_state = 32'h03dd7193;
    logic                 hold_credits;     // receiver keeps its credits.
    logic                 keep_result;      // model expects the closing integration.
    int                   errors = 0;
    int                   checks = 0;
    int                   cycles = 0;
    int                   frames_exp = 0;
    int                   frames_rx = 0;
    int                   rx_bytes = 0;
    int                   owed = 0;         // credits not yet returned.
    int                   model_nsmp = 0;
    int                   model_cnt [words];
    int                   last_counts [words];
    logic [num_lines-1:0] model_hist [num_lags];   // [k] is k samples back.
    xc_pkg::result_word_t exp_q [$];
    xc_pkg::link_byte_t   rx_q [$];

    xc_clock_gen i_clock_gen (
        .sysclk(sysclk),
        .arst_n(arst_n)
    );

    xc_core i_xc_core (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .line_in   (line_in),
        .smp_en    (smp_en),
        .enable    (enable),
        .out_valid (out_valid),
        .out_byte  (out_byte),
        .out_credit(out_credit),
        .overrun   (overrun)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // position of pair (a,b) when pairs are listed i-major, j from i up.
    function automatic int pair_index(input int a, input int b);
        int p;
        p = 0;
        for (int i = 0; i < num_lines; i++) begin
            for (int j = i; j < num_lines; j++) begin
                if (i == a && j == b)
                    return p;
                p++;
            end
        end
        return -1;
    endfunction

    task automatic compare_value(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // reference counts, one accepted sample at a time.
    task automatic model_accept(input logic [num_lines-1:0] lines);
        int p;
        xc_pkg::result_word_t w;
        for (int k = num_lags - 1; k > 0; k--) begin
            model_hist[k] = model_hist[k-1];
        end
        model_hist[0] = lines;
        p = 0;
        for (int i = 0; i < num_lines; i++) begin
            for (int j = i; j < num_lines; j++) begin
                for (int k = 0; k < num_lags; k++) begin
                    if (lines[i] && model_hist[k][j])
                        model_cnt[p*num_lags + k]++;
                end
                p++;
            end
        end
        model_nsmp++;
        if (model_nsmp == integ) begin
            if (keep_result) begin
                for (int n = 0; n < words; n++) begin
                    w.count      = model_cnt[n];
                    w.frame_last = (n == words - 1);
                    exp_q.push_back(w);
                end
                frames_exp++;
            end
            for (int n = 0; n < words; n++) begin
                model_cnt[n] = 0;
            end
            model_nsmp = 0;   // history carries on.
        end
    endtask

    task automatic apply_sample(input logic [num_lines-1:0] lines, input logic en);
        @(posedge sysclk);
        line_in <= lines;
        smp_en  <= 1'b1;
        enable  <= en;
        repeat (smp_div - 1) @(posedge sysclk);
        smp_en <= 1'b0;
        if (en)
            model_accept(lines);   // dropped strobes never reach the model.
    endtask

    task automatic integrate(input int mode, input int count, input logic en);
        logic [num_lines-1:0] lines;
        for (int s = 0; s < count; s++) begin
            case (mode)
                mode_ones:   lines = '1;
                mode_zeros:  lines = '0;
                mode_single: lines = num_lines'(1) << single_line;
                mode_alt: begin
                    for (int b = 0; b < num_lines; b++) begin
                        lines[b] = ((b + s) % 2 == 1);   // checkerboard in time.
                    end
                end
                default: begin
                    rng_state = xorshift32(rng_state);
                    lines     = rng_state[num_lines-1:0];
                end
            endcase
            apply_sample(lines, en);
        end
    endtask

    task automatic drain_frames();
        while (frames_rx < frames_exp || owed != 0) begin
            @(posedge sysclk);
        end
    endtask

    task automatic check_frame();
        xc_pkg::link_byte_t   fb [frame_bytes];
        xc_pkg::result_word_t ew;
        logic [7:0]           sum;
        for (int b = 0; b < frame_bytes; b++) begin
            fb[b] = rx_q.pop_front();
        end
        compare_value("frame header", fb[0].data, `XC_FRAME_HEADER);
        if (exp_q.size() < words) begin
            errors++;
            $display("A frame arrived at %0d ns while no result was pending.", $time);
        end else begin
            sum = 8'h00;
            for (int w = 0; w < words; w++) begin
                ew             = exp_q.pop_front();
                last_counts[w] = {fb[2*w+1].data, fb[2*w+2].data};   // msb first.
                compare_value($sformatf("count word %0d", w), last_counts[w], ew.count);
                sum = sum ^ ew.count[15:8] ^ ew.count[7:0];   // from the model counts.
            end
            compare_value("frame checksum", fb[frame_bytes-1].data, sum);
        end
        frames_rx++;
    endtask

    // receiver, one credit back per byte unless held.
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge sysclk);
            if (arst_n) begin
                if (out_valid) begin
                    rx_q.push_back(out_byte);
                    rx_bytes++;
                    owed++;
                end
                if (!hold_credits && owed > 0) begin
                    out_credit <= 1'b1;
                    owed--;
                end else begin
                    out_credit <= 1'b0;
                end
                if (rx_q.size() == frame_bytes)
                    check_frame();
            end
        end
    end

    always @(posedge sysclk) begin
        cycles++;
        if (cycles == timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
            $display("Summary: %0d checks, %0d errors, %0d frames", checks, errors, frames_rx);
            $display("Done: errors found");
            $finish;
        end
    end

    // lag history crosses the boundary between the two frames.
    task automatic random_lines_test();
        integrate(mode_random, integ, 1'b1);
        drain_frames();
        integrate(mode_random, integ, 1'b1);
        drain_frames();
    endtask

    task automatic constant_patterns_test();
        int p;
        integrate(mode_ones, integ, 1'b1);
        drain_frames();
        for (int q = 0; q < `XC_NUM_PAIRS; q++) begin
            compare_value("all ones at lag 0", last_counts[q*num_lags], integ);
        end
        integrate(mode_zeros, integ, 1'b1);
        drain_frames();
        for (int n = 0; n < words; n++) begin
            compare_value("all zeros", last_counts[n], 0);
        end
        integrate(mode_single, integ, 1'b1);   // follows zeros, so k early samples miss.
        drain_frames();
        p = pair_index(single_line, single_line);
        for (int q = 0; q < `XC_NUM_PAIRS; q++) begin
            for (int k = 0; k < num_lags; k++) begin
                compare_value("single line", last_counts[q*num_lags + k],
                              (q == p) ? integ - k : 0);
            end
        end
    endtask

    task automatic framing_test();
        int start;
        start = rx_bytes;
        integrate(mode_alt, integ, 1'b1);
        drain_frames();
        compare_value("frame length", rx_bytes - start, frame_bytes);
        compare_value("leftover bytes", rx_q.size(), 0);
    endtask

    // counts of this frame are checked against the model by the receiver.
    task automatic enable_gap_test();
        integrate(mode_random, integ / 2, 1'b1);
        integrate(mode_random, 6, 1'b0);   // strobes with enable low.
        integrate(mode_random, integ - integ / 2, 1'b1);
        drain_frames();
    endtask

    task automatic credit_stall_test();
        int start;
        compare_value("overrun before stall", overrun, 0);
        start = rx_bytes;
        hold_credits <= 1'b1;
        integrate(mode_random, integ, 1'b1);   // held in the shadow bank.
        keep_result = 1'b0;
        integrate(mode_random, integ, 1'b1);   // ends during readout, lost.
        keep_result = 1'b1;
        repeat (16) begin
            @(posedge sysclk);
            compare_value("out_valid without credits", out_valid, 0);
        end
        compare_value("bytes sent on initial credits", rx_bytes - start, `XC_OUT_CREDITS);
        compare_value("overrun after lost result", overrun, 1);
        hold_credits <= 1'b0;
        drain_frames();
    endtask

    initial begin
        line_in      = '0;
        smp_en       = 1'b0;
        enable       = 1'b0;
        hold_credits = 1'b0;
        keep_result  = 1'b1;
        for (int k = 0; k < num_lags; k++) begin
            model_hist[k] = '0;
        end
        for (int n = 0; n < words; n++) begin
            model_cnt[n]   = 0;
            last_counts[n] = 0;
        end
        @(posedge arst_n);
        repeat (2) @(posedge sysclk);
        random_lines_test();
        constant_patterns_test();
        framing_test();
        enable_gap_test();
        credit_stall_test();
        repeat (10) @(posedge sysclk);
        compare_value("results never received", exp_q.size(), 0);
        compare_value("bytes outside a frame", rx_q.size(), 0);
        $display("Summary: %0d checks, %0d errors, %0d frames", checks, errors, frames_rx);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: xc_core.f
+incdir+src
src/xc_pkg.sv
src/xc_line_sampler.sv
src/xc_lag_window.sv
src/xc_correlator.sv
src/xc_credit_fifo.sv
src/xc_framer.sv
src/xc_core.sv
bench/xc_clock_gen.sv
bench/xc_core_assertions.sv
bench/xc_tb.sv

// File: Bender.yml
package:
  name: xc_core

export_include_dirs:
  - src

sources:
  - files:
      - src/xc_pkg.sv
      - src/xc_line_sampler.sv
      - src/xc_lag_window.sv
      - src/xc_correlator.sv
      - src/xc_credit_fifo.sv
      - src/xc_framer.sv
      - src/xc_core.sv
  - target: test
    files:
      - bench/xc_clock_gen.sv
      - bench/xc_core_assertions.sv
      - bench/xc_tb.sv
